//--- rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam xlen_t RESET_PC = 32'h8000_0000;

    // Major opcodes of the supported instructions.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD = 3'b000;   // Shared by add and addi.

    typedef enum logic [2:0] {
        CMD_NONE = 3'd0,                      // Illegal or unsupported.
        CMD_ADD  = 3'd1,
        CMD_ADDI = 3'd2,
        CMD_LUI  = 3'd3,
        CMD_HALT = 3'd4
    } exu_cmd_e;

    typedef enum logic [1:0] {
        ST_RUN  = 2'd0,
        ST_HALT = 2'd1,
        ST_TRAP = 2'd2
    } ctrl_state_e;

endpackage

//--- rtl/rf_read_if.sv
`timescale 1ns/1ps

interface rf_read_if;

    core_pkg::reg_addr_t raddr1;
    core_pkg::reg_addr_t raddr2;
    core_pkg::xlen_t     rdata1;
    core_pkg::xlen_t     rdata2;

    modport decoder (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    modport regfile (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );

endinterface

//--- rtl/dec_if.sv
`timescale 1ns/1ps

interface dec_if;

    core_pkg::xlen_t     src1;
    core_pkg::xlen_t     src2;
    core_pkg::reg_addr_t des;     // Zero when nothing is written.
    core_pkg::xlen_t     imm;
    core_pkg::exu_cmd_e  command;

    modport decoder (
        output src1,
        output src2,
        output des,
        output imm,
        output command
    );

    modport execute (
        input  src1,
        input  src2,
        input  des,
        input  imm,
        input  command
    );

endinterface

//--- rtl/core_ifu.sv
`timescale 1ns/1ps

module core_ifu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_en,
    output core_pkg::xlen_t pc
);

    core_pkg::xlen_t pc_next;

    assign pc_next = pc + core_pkg::xlen_t'(4);   // Sequential fetch only.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= core_pkg::RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    // The reset vector and the step are both multiples of four.
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

//--- rtl/core_idu.sv
`timescale 1ns/1ps

module core_idu (
    input  core_pkg::inst_t inst,
    rf_read_if.decoder      rf,
    dec_if.decoder          dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    core_pkg::xlen_t imm_i;
    core_pkg::xlen_t imm_u;

    logic src1_en;
    logic src2_en;
    logic write_en;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};   // Sign extended.
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec.command = core_pkg::CMD_NONE;
        dec.imm     = '0;
        src1_en     = 1'b0;
        src2_en     = 1'b0;
        write_en    = 1'b0;
        case (opcode)
            core_pkg::OPC_OP_IMM: begin
                if (funct3 == core_pkg::F3_ADD) begin   // addi
                    dec.command = core_pkg::CMD_ADDI;
                    dec.imm     = imm_i;
                    src1_en     = 1'b1;
                    write_en    = 1'b1;
                end
            end
            core_pkg::OPC_OP: begin
                if (funct3 == core_pkg::F3_ADD && funct7 == 7'b0) begin   // add
                    dec.command = core_pkg::CMD_ADD;
                    src1_en     = 1'b1;
                    src2_en     = 1'b1;
                    write_en    = 1'b1;
                end
            end
            core_pkg::OPC_LUI: begin
                dec.command = core_pkg::CMD_LUI;
                dec.imm     = imm_u;
                write_en    = 1'b1;
            end
            core_pkg::OPC_SYSTEM: begin
                // Only ebreak, ecall and the rest trap.
                if (inst[31:7] == {12'h001, 13'h0}) begin
                    dec.command = core_pkg::CMD_HALT;
                end
            end
            default: begin
            end
        endcase
    end

    // Unused fields are forced to zero.
    assign rf.raddr1 = src1_en ? inst[19:15] : '0;
    assign rf.raddr2 = src2_en ? inst[24:20] : '0;
    assign dec.src1  = src1_en ? rf.rdata1 : '0;
    assign dec.src2  = src2_en ? rf.rdata2 : '0;
    assign dec.des   = write_en ? inst[11:7] : '0;

endmodule

//--- rtl/core_exu.sv
`timescale 1ns/1ps

module core_exu (
    dec_if.execute              dec,
    input  logic                wb_allow,
    output logic                wen,
    output core_pkg::reg_addr_t waddr,
    output core_pkg::xlen_t     wdata
);

    logic writes_reg;

    always_comb begin
        wdata      = '0;
        writes_reg = 1'b0;
        case (dec.command)
            core_pkg::CMD_ADD: begin
                wdata      = dec.src1 + dec.src2;   // Wraps modulo 2^32.
                writes_reg = 1'b1;
            end
            core_pkg::CMD_ADDI: begin
                wdata      = dec.src1 + dec.imm;
                writes_reg = 1'b1;
            end
            core_pkg::CMD_LUI: begin
                wdata      = dec.imm;
                writes_reg = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign wen   = writes_reg && wb_allow;   // Controller blocks writes once halted.
    assign waddr = dec.des;

endmodule

//--- rtl/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
    input  logic                clk,
    input  logic                rst_n,
    rf_read_if.regfile          rf,
    input  logic                wen,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::xlen_t     wdata
);

    core_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wen && waddr != '0) begin   // x0 stays zero.
            regs[waddr] <= wdata;
        end
    end

    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wen |-> !$isunknown(wdata)
    ) else $error("unknown write data to x%0d", waddr);

endmodule

//--- rtl/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::exu_cmd_e command,
    output logic               pc_en,
    output logic               wb_allow,
    output logic               halted,
    output logic               illegal
);

    core_pkg::ctrl_state_e state;
    core_pkg::ctrl_state_e state_next;

    logic stop_cmd;

    assign stop_cmd = (command == core_pkg::CMD_HALT) || (command == core_pkg::CMD_NONE);

    always_comb begin
        state_next = state;
        if (state == core_pkg::ST_RUN) begin
            if (command == core_pkg::CMD_HALT) begin
                state_next = core_pkg::ST_HALT;
            end else if (command == core_pkg::CMD_NONE) begin
                state_next = core_pkg::ST_TRAP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= core_pkg::ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    // PC holds on the stopping instruction itself.
    assign pc_en    = (state == core_pkg::ST_RUN) && !stop_cmd;
    assign wb_allow = (state == core_pkg::ST_RUN);
    assign halted   = (state != core_pkg::ST_RUN);
    assign illegal  = (state == core_pkg::ST_TRAP);

    // Halt and trap are sticky until reset.
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state != core_pkg::ST_RUN) |=> (state != core_pkg::ST_RUN)
    ) else $error("controller left halt without reset");

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                clk,
    input  logic                rst_n,
    output core_pkg::xlen_t     pc,
    input  core_pkg::inst_t     inst,
    output logic                commit_valid,
    output core_pkg::reg_addr_t commit_addr,
    output core_pkg::xlen_t     commit_data,
    output logic                halted,
    output logic                illegal
);

    logic                pc_en;
    logic                wb_allow;
    logic                wen;
    core_pkg::reg_addr_t waddr;
    core_pkg::xlen_t     wdata;

    rf_read_if i_rf_rd ();
    dec_if     i_dec ();

    core_ifu i_ifu (
        .clk   (clk),
        .rst_n (rst_n),
        .pc_en (pc_en),
        .pc    (pc)
    );

    core_idu i_idu (
        .inst (inst),
        .rf   (i_rf_rd.decoder),
        .dec  (i_dec.decoder)
    );

    core_exu i_exu (
        .dec      (i_dec.execute),
        .wb_allow (wb_allow),
        .wen      (wen),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    core_regfile i_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (i_rf_rd.regfile),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata)
    );

    core_ctrl i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .command  (i_dec.command),
        .pc_en    (pc_en),
        .wb_allow (wb_allow),
        .halted   (halted),
        .illegal  (illegal)
    );

    // x0 writes are requested but never land.
    assign commit_valid = wen && (waddr != '0);
    assign commit_addr  = waddr;
    assign commit_data  = wdata;

endmodule

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int              CLK_PERIOD   = 100;
    localparam int              DRIVE_DELAY  = 1;
    localparam int              RESET_CYCLES = 5;
    localparam int              HOLD_CYCLES  = 2;    // Cycles watched after the halt shows.
    localparam core_pkg::inst_t ILLEGAL_WORD = 32'h0000_0000;
    localparam string           DATA_FILE    = "verification/core_testdata.txt";

    logic                clk;
    logic                rst_n;
    core_pkg::xlen_t     pc;
    core_pkg::inst_t     inst;
    logic                commit_valid;
    core_pkg::reg_addr_t commit_addr;
    core_pkg::xlen_t     commit_data;
    logic                halted;
    logic                illegal;

    // Program words and expected results hold one slice per program section.
    core_pkg::inst_t     prog_words [$];
    int                  prog_start [$];
    int                  prog_count [$];
    core_pkg::reg_addr_t exp_addr [$];
    core_pkg::xlen_t     exp_data [$];
    int                  exp_start [$];
    int                  exp_count [$];
    core_pkg::xlen_t     halt_pc [$];
    logic                halt_illegal [$];

    int   cur_sect;
    logic section_open;
    logic load_done;

    core_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit_addr  (commit_addr),
        .commit_data  (commit_data),
        .halted       (halted),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic open_section();
        if (!section_open) begin
            prog_start.push_back(prog_words.size());
            exp_start.push_back(exp_addr.size());
            section_open = 1'b1;
        end
    endtask

    task automatic load_testdata();
        int              fd;
        int              n;
        int              reg_num;
        int              ill;
        string           line;
        string           body;
        logic [31:0]     word;
        core_pkg::xlen_t value;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("Could not open the data file %s", DATA_FILE));
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() >= 2) begin
                body = line.substr(1, line.len() - 1);
                case (line.getc(0))
                    "#": begin
                    end
                    "I": begin
                        open_section();
                        if ($sscanf(body, "%h", word) != 1) begin
                            abort_run($sformatf("Bad program line in data file: %s", line));
                        end
                        prog_words.push_back(word);
                    end
                    "W": begin
                        open_section();
                        if ($sscanf(body, "%d %h", reg_num, value) != 2
                                || reg_num < 1 || reg_num > 31) begin
                            abort_run($sformatf("Bad commit line in data file: %s", line));
                        end
                        exp_addr.push_back(core_pkg::reg_addr_t'(reg_num));
                        exp_data.push_back(value);
                    end
                    "H": begin
                        if (!section_open || $sscanf(body, "%h %d", value, ill) != 2) begin
                            abort_run($sformatf("Bad halt line in data file: %s", line));
                        end
                        prog_count.push_back(prog_words.size() - prog_start[$]);
                        exp_count.push_back(exp_addr.size() - exp_start[$]);
                        halt_pc.push_back(value);
                        halt_illegal.push_back(ill != 0);
                        section_open = 1'b0;
                    end
                    default: begin
                        abort_run($sformatf("Unknown line in data file: %s", line));
                    end
                endcase
            end
        end
        $fclose(fd);
        if (section_open || halt_pc.size() == 0) begin
            abort_run("The data file has a program section without a halt line");
        end
    endtask

    // Instruction memory of the current section is word addressed from the reset vector.
    function automatic core_pkg::inst_t fetch_word(input core_pkg::xlen_t addr);
        core_pkg::xlen_t offset;
        int              index;
        if ($isunknown(addr) || addr < core_pkg::RESET_PC) begin
            return ILLEGAL_WORD;
        end
        offset = addr - core_pkg::RESET_PC;
        if (offset[1:0] != 2'b00) begin
            return ILLEGAL_WORD;
        end
        if (offset >= core_pkg::xlen_t'(prog_count[cur_sect] * 4)) begin
            return ILLEGAL_WORD;                     // Past the end of the program.
        end
        index = prog_start[cur_sect] + int'(offset >> 2);
        return prog_words[index];
    endfunction

    // Drives just after the edge and returns mid cycle for sampling.
    task automatic step_cycle(input logic rst_value);
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = rst_value;
        inst  = rst_value ? fetch_word(pc) : ILLEGAL_WORD;
        @(negedge clk);
    endtask

    task automatic run_section(input int s);
        core_pkg::xlen_t exp_pc;
        int              next_exp;
        int              last_exp;
        cur_sect = s;
        exp_pc   = core_pkg::RESET_PC;
        next_exp = exp_start[s];
        last_exp = exp_start[s] + exp_count[s];

        repeat (RESET_CYCLES) step_cycle(1'b0);
        check_value("pc", pc, core_pkg::RESET_PC);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("halted", 32'(halted), 32'd0);
        check_value("illegal", 32'(illegal), 32'd0);

        step_cycle(1'b1);
        while (halted !== 1'b1) begin
            check_value("pc", pc, exp_pc);
            if (commit_valid === 1'b1) begin
                if (next_exp >= last_exp) begin
                    abort_run($sformatf("Unexpected commit to x%0d at %0d ns in section %0d",
                                        commit_addr, $time, s));
                end
                check_value("commit_addr", 32'(commit_addr), 32'(exp_addr[next_exp]));
                check_value("commit_data", commit_data, exp_data[next_exp]);
                next_exp = next_exp + 1;
            end
            exp_pc = exp_pc + 32'd4;
            step_cycle(1'b1);
        end

        // Halt state must hold with the pc frozen and no writes.
        for (int i = 0; i <= HOLD_CYCLES; i++) begin
            check_value("halted", 32'(halted), 32'd1);
            check_value("illegal", 32'(illegal), 32'(halt_illegal[s]));
            check_value("pc", pc, halt_pc[s]);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
            if (i < HOLD_CYCLES) begin
                step_cycle(1'b1);
            end
        end
        if (next_exp != last_exp) begin
            abort_run($sformatf("Section %0d halted with %0d expected commits never seen",
                                s, last_exp - next_exp));
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        inst         = ILLEGAL_WORD;
        cur_sect     = 0;
        section_open = 1'b0;
        load_done    = 1'b0;
        load_testdata();
        load_done = 1'b1;
        for (int s = 0; s < halt_pc.size(); s++) begin
            run_section(s);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        wait (load_done === 1'b1);
        #((prog_words.size() + 20) * CLK_PERIOD);
        abort_run("Timeout, the core did not finish all program sections in time");
    end

endmodule

//--- verification/core_testdata.txt
# I <instruction word, hex>    W <register, decimal> <commit value, hex>
# H <halt pc, hex> <illegal flag 0/1>, one H line closes each program section.
# Section 0 runs addi, lui and add and stops at ebreak.
I 00500093   # addi x1, x0, 5
I ffd08113   # addi x2, x1, -3
I 80000193   # addi x3, x0, -2048
I 12345237   # lui  x4, 0x12345
I 001202b3   # add  x5, x4, x1
I 80000337   # lui  x6, 0x80000
I 00130313   # addi x6, x6, 1
I 006303b3   # add  x7, x6, x6 wraps
I 00708013   # addi x0, x1, 7 not committed
I 00300433   # add  x8, x0, x3
I abcde037   # lui  x0, 0xabcde not committed
I fff00513   # addi x10, x0, -1
I 00100073   # ebreak
I 00900593   # addi x11, x0, 9 never reached
W 1 00000005
W 2 00000002
W 3 fffff800
W 4 12345000
W 5 12345005
W 6 80000000
W 6 80000001
W 7 00000002
W 8 fffff800
W 10 ffffffff
H 80000030 0
# Section 1 starts from a fresh reset and ends in sub, which is unsupported.
I 06400093   # addi x1, x0, 100
I 00108133   # add  x2, x1, x1
I 000501b3   # add  x3, x10, x0 after reset
I 40108233   # sub  x4, x1, x1
I 00100293   # addi x5, x0, 1 never reached
W 1 00000064
W 2 000000c8
W 3 00000000
H 8000000c 1

//--- src.f
rtl/core_pkg.sv
rtl/rf_read_if.sv
rtl/dec_if.sv
rtl/core_ifu.sv
rtl/core_idu.sv
rtl/core_exu.sv
rtl/core_regfile.sv
rtl/core_ctrl.sv
rtl/core_top.sv
verification/core_tb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f src.f --top-module core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
